/* include/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Cache geometry
`define CACHE_LINE_BYTES 16
`define CACHE_NUM_WAYS   4
`define CACHE_NUM_SETS   4
`define CACHE_SIZE_BYTES 256

// Backing data memory, depth in lines
`define DMEM_NUM_LINES   1024
// Cycles from an accepted request to mem_done
`define DMEM_LATENCY     4

// Byte-address bits that reach the memory
`define ADDR_BITS        14

`endif

/* rtl/cache_pkg.sv */
`include "cache_params.svh"

package cache_pkg;

  typedef logic [31:0] word_t;
  typedef logic [`CACHE_LINE_BYTES*8-1:0] line_t;
  typedef logic [31:0] addr_t;

  // Address bits above set index and line offset
  typedef logic [`ADDR_BITS-$clog2(`CACHE_SIZE_BYTES/`CACHE_NUM_WAYS)-1:0] tag_t;
  typedef logic [$clog2(`CACHE_NUM_SETS)-1:0] set_idx_t;
  typedef logic [$clog2(`CACHE_NUM_WAYS)-1:0] way_idx_t;
  typedef logic [$clog2(`CACHE_LINE_BYTES/4)-1:0] word_sel_t;

  typedef enum logic [1:0] {
    ctrl_idle,
    ctrl_writeback,
    ctrl_refill
  } cache_state_t;

  // Processor-side request, held until it hits
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    word_t wdata;
  } cache_req_t;

  // Line-wide request to the data memory
  typedef struct packed {
    logic                               valid;
    logic                               read;
    logic                               write;
    logic [$clog2(`DMEM_NUM_LINES)-1:0] line_addr;
    line_t                              wline;
  } mem_req_t;

endpackage

/* rtl/cache_lookup.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_lookup
  import cache_pkg::*;
(
  input  tag_t                           tag,
  input  logic     [`CACHE_NUM_WAYS-1:0] set_valid,
  input  logic     [`CACHE_NUM_WAYS-1:0] set_dirty,
  input  tag_t     [`CACHE_NUM_WAYS-1:0] set_tags,
  input  way_idx_t [`CACHE_NUM_WAYS-1:0] set_ages,
  output logic                           hit,
  output way_idx_t                       hit_way,
  output way_idx_t                       victim_way,
  output logic                           victim_dirty
);

  logic     free_found;
  way_idx_t free_way;
  way_idx_t oldest_way;
  way_idx_t oldest_age;

  // Tag compare against every valid way of the set
  always_comb begin
    hit = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      if (set_valid[w] && set_tags[w] == tag) begin
        hit = 1'b1;
        hit_way = way_idx_t'(w);
      end
    end
  end

  // Highest-numbered invalid way wins
  always_comb begin
    free_found = 1'b0;
    free_way = '0;
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      if (!set_valid[w]) begin
        free_found = 1'b1;
        free_way = way_idx_t'(w);
      end
    end
  end

  // Oldest way, ties go to the higher way number
  always_comb begin
    oldest_age = set_ages[0];
    oldest_way = '0;
    for (int w = 1; w < `CACHE_NUM_WAYS; w++) begin
      if (set_ages[w] >= oldest_age) begin
        oldest_age = set_ages[w];
        oldest_way = way_idx_t'(w);
      end
    end
  end

  assign victim_way   = free_found ? free_way : oldest_way;
  assign victim_dirty = set_dirty[victim_way];

endmodule

/* rtl/data_cache.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module data_cache
  import cache_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  cache_req_t req,
  input  logic       mem_ready,
  input  logic       mem_done,
  input  line_t      rline,
  output logic       is_hit,
  output logic       is_output_valid,
  output word_t      rdata,
  output logic       is_ready,
  output mem_req_t   mem_req
);

  localparam int OFFSET_BITS = $clog2(`CACHE_LINE_BYTES);
  localparam way_idx_t AGE_MAX = way_idx_t'(`CACHE_NUM_WAYS - 1);

  cache_state_t state;
  cache_state_t next_state;

  // Per-set banks, one entry per way
  logic     [`CACHE_NUM_WAYS-1:0] valid_bank [`CACHE_NUM_SETS];
  logic     [`CACHE_NUM_WAYS-1:0] dirty_bank [`CACHE_NUM_SETS];
  way_idx_t [`CACHE_NUM_WAYS-1:0] age_bank   [`CACHE_NUM_SETS];
  tag_t     [`CACHE_NUM_WAYS-1:0] tag_bank   [`CACHE_NUM_SETS];
  line_t                          data_bank  [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];

  tag_t      req_tag;
  set_idx_t  req_set;
  word_sel_t req_word;

  logic     lookup_hit;
  way_idx_t hit_way;
  way_idx_t victim_way;
  logic     victim_dirty;

  logic serve_hit;
  logic miss;
  logic refill_done;

  assign req_tag  = req.addr[`ADDR_BITS-1 -: $bits(tag_t)];
  assign req_set  = req.addr[OFFSET_BITS +: $bits(set_idx_t)];
  assign req_word = req.addr[2 +: $bits(word_sel_t)];

  cache_lookup lookup_i (
    .tag          (req_tag),
    .set_valid    (valid_bank[req_set]),
    .set_dirty    (dirty_bank[req_set]),
    .set_tags     (tag_bank[req_set]),
    .set_ages     (age_bank[req_set]),
    .hit          (lookup_hit),
    .hit_way      (hit_way),
    .victim_way   (victim_way),
    .victim_dirty (victim_dirty)
  );

  assign is_hit          = req.valid & lookup_hit;
  assign is_output_valid = is_hit & ~req.write;
  assign is_ready        = (state == ctrl_idle);
  assign rdata           = data_bank[req_set][hit_way][32*req_word +: 32];

  assign serve_hit   = is_ready & is_hit;
  assign miss        = is_ready & req.valid & ~lookup_hit;
  assign refill_done = (state == ctrl_refill) & mem_done;

  // The first memory access already goes out in the cycle the miss is seen
  always_comb begin
    mem_req.valid = 1'b0;
    mem_req.read  = 1'b0;
    mem_req.write = 1'b0;
    case (state)
      ctrl_idle: begin
        mem_req.valid = miss;
        mem_req.read  = miss & ~victim_dirty;
        mem_req.write = miss & victim_dirty;
      end
      ctrl_writeback: begin
        mem_req.valid = 1'b1;
        mem_req.write = 1'b1;
      end
      ctrl_refill: begin
        mem_req.valid = 1'b1;
        mem_req.read  = 1'b1;
      end
      default: ;
    endcase
    // Victim line address on write-back, requested line on refill
    mem_req.line_addr = mem_req.write ? {tag_bank[req_set][victim_way], req_set}
                                      : req.addr[`ADDR_BITS-1:OFFSET_BITS];
    mem_req.wline = data_bank[req_set][victim_way];
  end

  always_comb begin
    next_state = state;
    case (state)
      ctrl_idle:      if (miss) next_state = victim_dirty ? ctrl_writeback : ctrl_refill;
      ctrl_writeback: if (mem_done) next_state = ctrl_refill;
      ctrl_refill:    if (mem_done) next_state = ctrl_idle;
      default:        next_state = ctrl_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ctrl_idle;
      for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
        valid_bank[s] <= '0;
        dirty_bank[s] <= '0;
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
          age_bank[s][w] <= way_idx_t'(w);
        end
      end
    end else begin
      state <= next_state;
      if (serve_hit) begin
        // Age the set, saturating at the oldest value
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
          if (age_bank[req_set][w] != AGE_MAX) begin
            age_bank[req_set][w] <= age_bank[req_set][w] + 1'b1;
          end
        end
        age_bank[req_set][hit_way] <= '0;
        if (req.write) begin
          dirty_bank[req_set][hit_way] <= 1'b1;
        end
      end
      // Refilled way keeps its age until the retried request hits
      if (refill_done) begin
        valid_bank[req_set][victim_way] <= 1'b1;
        dirty_bank[req_set][victim_way] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (serve_hit && req.write) begin
      data_bank[req_set][hit_way][32*req_word +: 32] <= req.wdata;
    end
    if (refill_done) begin
      tag_bank[req_set][victim_way] <= req_tag;
      data_bank[req_set][victim_way] <= rline;
    end
  end

endmodule

/* rtl/data_memory.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module data_memory
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  mem_req_t mem_req,
  output logic     mem_ready,
  output logic     mem_done,
  output line_t    rline
);

  localparam int LINE_ADDR_BITS = $clog2(`DMEM_NUM_LINES);
  localparam int CNT_BITS = $clog2(`DMEM_LATENCY + 1);

  line_t mem_array [`DMEM_NUM_LINES];

  logic                      busy;
  logic [CNT_BITS-1:0]       count;
  logic                      accept;
  logic                      pend_write;
  logic [LINE_ADDR_BITS-1:0] pend_line;
  line_t                     pend_wline;

  assign mem_ready = ~busy;
  assign accept    = mem_ready & mem_req.valid & (mem_req.read | mem_req.write);
  assign mem_done  = busy & (count == '0);

  // Read data is valid only while mem_done is high
  assign rline = mem_array[pend_line];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      count <= '0;
      // Word k of line n holds (4n + k) ^ 32'h5a5a_0000
      for (int n = 0; n < `DMEM_NUM_LINES; n++) begin
        for (int k = 0; k < `CACHE_LINE_BYTES / 4; k++) begin
          mem_array[n][32*k +: 32] <= word_t'(n * 4 + k) ^ 32'h5a5a_0000;
        end
      end
    end else begin
      if (accept) begin
        busy  <= 1'b1;
        count <= CNT_BITS'(`DMEM_LATENCY - 1);
      end else if (mem_done) begin
        busy <= 1'b0;
        if (pend_write) begin
          mem_array[pend_line] <= pend_wline;
        end
      end else if (busy) begin
        count <= count - 1'b1;
      end
    end
  end

  // Request payload, captured on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      pend_write <= mem_req.write;
      pend_line  <= mem_req.line_addr;
      pend_wline <= mem_req.wline;
    end
  end

endmodule

/* rtl/cache_top.sv */
`timescale 1ns/1ps

module cache_top
  import cache_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  cache_req_t req,
  output logic       is_hit,
  output logic       is_output_valid,
  output word_t      rdata,
  output logic       is_ready
);

  mem_req_t mem_req;
  logic     mem_ready;
  logic     mem_done;
  line_t    rline;

  data_cache data_cache_i (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .mem_ready       (mem_ready),
    .mem_done        (mem_done),
    .rline           (rline),
    .is_hit          (is_hit),
    .is_output_valid (is_output_valid),
    .rdata           (rdata),
    .is_ready        (is_ready),
    .mem_req         (mem_req)
  );

  data_memory data_memory_i (
    .clk       (clk),
    .reset     (reset),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .mem_done  (mem_done),
    .rline     (rline)
  );

endmodule

/* verif/cache_checker.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_checker
  import cache_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  cache_req_t req,
  input  logic       is_hit,
  input  logic       is_output_valid,
  input  word_t      rdata,
  input  logic       is_ready,
  input  int         test_id,
  output int         error_count,
  output int         check_count
);

  localparam int SET_LSB = $clog2(`CACHE_LINE_BYTES);
  localparam way_idx_t AGE_MAX = way_idx_t'(`CACHE_NUM_WAYS - 1);

  // Flat word image of memory, and the expected tag and age state per set
  word_t    model_mem   [`DMEM_NUM_LINES * 4];
  logic     model_valid [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
  tag_t     model_tag   [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
  way_idx_t model_age   [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
  logic     first_cycle;
  int       cur_test;
  int       test_errors;
  string    test_names [6] = '{"idle", "cold_reads", "write_read", "dirty_eviction",
                               "lru_order", "random_mix"};

  // Expected read data is the last value written, else the reset pattern
  function automatic word_t expected_rdata(input addr_t addr);
    return model_mem[addr[`ADDR_BITS-1:2]];
  endfunction

  function automatic int resident_way(input addr_t addr);
    set_idx_t s = addr[SET_LSB +: $bits(set_idx_t)];
    tag_t     t = addr[`ADDR_BITS-1 -: $bits(tag_t)];
    int       way = -1;
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      if (model_valid[s][w] && model_tag[s][w] == t) begin
        way = w;
      end
    end
    return way;
  endfunction

  task automatic check_value(input string what, input word_t expected, input word_t actual);
    check_count++;
    if (expected !== actual) begin
      error_count++;
      test_errors++;
      $display("CHECK FAILED %s: %s at addr %h, expected %h, actual %h",
               test_names[cur_test], what, req.addr, expected, actual);
    end
  endtask

  // Outputs are sampled mid-cycle, away from the driving edge
  always @(negedge clk) begin
    set_idx_t s;
    int       way;
    logic     exp_hit;
    s = req.addr[SET_LSB +: $bits(set_idx_t)];
    if (reset) begin
      for (int i = 0; i < `DMEM_NUM_LINES * 4; i++) begin
        model_mem[i] = word_t'(i) ^ 32'h5a5a_0000;
      end
      for (int n = 0; n < `CACHE_NUM_SETS; n++) begin
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
          model_valid[n][w] = 1'b0;
          model_age[n][w] = way_idx_t'(w);
        end
      end
      first_cycle = 1'b1;
      cur_test = 0;
      test_errors = 0;
      error_count = 0;
      check_count = 0;
    end else begin
      if (test_id != cur_test) begin
        if (cur_test != 0) begin
          $display("Test %s finished with %0d errors", test_names[cur_test], test_errors);
        end
        if (test_id == 0) begin
          $display("Summary: %0d checks, %0d errors", check_count, error_count);
        end
        cur_test = test_id;
        test_errors = 0;
      end
      if (req.valid) begin
        if (first_cycle) begin
          if (!is_ready) begin
            error_count++;
            test_errors++;
            $display("%s: a new request started while the cache was busy",
                     test_names[cur_test]);
          end
          way = resident_way(req.addr);
          exp_hit = (way >= 0);
          check_value("hit in first cycle", word_t'(exp_hit), word_t'(is_hit));
          if (way < 0) begin
            // Highest invalid way first, else the oldest, ties to the higher way
            for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
              if (!model_valid[s][w]) begin
                way = w;
              end
            end
            if (way < 0) begin
              way = 0;
              for (int w = 1; w < `CACHE_NUM_WAYS; w++) begin
                if (model_age[s][w] >= model_age[s][way]) begin
                  way = w;
                end
              end
            end
            model_valid[s][way] = 1'b1;
            model_tag[s][way] = req.addr[`ADDR_BITS-1 -: $bits(tag_t)];
          end
          first_cycle = 1'b0;
        end else begin
          // Missed line is absent while the cache is busy, and hits once it is idle again
          exp_hit = is_ready;
          check_value("hit after miss", word_t'(exp_hit), word_t'(is_hit));
        end
        check_value("output valid", word_t'(exp_hit && !req.write), word_t'(is_output_valid));
      end
      if (req.valid && is_hit && is_ready) begin
        way = resident_way(req.addr);
        if (req.write) begin
          model_mem[req.addr[`ADDR_BITS-1:2]] = req.wdata;
        end else begin
          check_value("read data", expected_rdata(req.addr), rdata);
        end
        // Hit way becomes youngest, the rest age up to the maximum
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
          if (model_age[s][w] != AGE_MAX) begin
            model_age[s][w]++;
          end
        end
        if (way >= 0) begin
          model_age[s][way] = '0;
        end
        first_cycle = 1'b1;
      end
    end
  end

endmodule

/* verif/cache_tb.sv */
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_tb
  import cache_pkg::*;
();

  localparam int RESET_CYCLES = 4;
  localparam int RANDOM_OPS = 300;
  localparam int RANDOM_LINES = 64;
  // About 400 requests at up to 12 cycles for a dirty miss, with roughly 4x margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic        clk;
  logic        reset;
  cache_req_t  req;
  logic        is_hit;
  logic        is_output_valid;
  word_t       rdata;
  logic        is_ready;
  int          test_id;
  int          error_count;
  int          check_count;
  int          cycle_count;
  integer      seed;
  logic [31:0] rnd;
  word_t       data;

  always #2 clk = ~clk;

  cache_top cache_top_i (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .is_hit          (is_hit),
    .is_output_valid (is_output_valid),
    .rdata           (rdata),
    .is_ready        (is_ready)
  );

  cache_checker cache_checker_i (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .is_hit          (is_hit),
    .is_output_valid (is_output_valid),
    .rdata           (rdata),
    .is_ready        (is_ready),
    .test_id         (test_id),
    .error_count     (error_count),
    .check_count     (check_count)
  );

  // Present one request and hold it until the cache completes it
  task automatic run_access(input logic wr, input int unsigned line, input int unsigned word,
                            input word_t wdata);
    logic completed;
    req.valid <= 1'b1;
    req.write <= wr;
    req.addr  <= addr_t'(line * `CACHE_LINE_BYTES + word * 4);
    req.wdata <= wdata;
    completed = 1'b0;
    while (!completed) begin
      @(negedge clk);
      completed = is_hit & is_ready;
      @(posedge clk);
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    req = '0;
    test_id = 0;
    cycle_count = 0;
    seed = 32'h79a2_a59b;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    // Every word of 8 lines, first word of each line misses
    test_id <= 1;
    for (int i = 0; i < 32; i++) begin
      run_access(1'b0, i / 4, i % 4, '0);
    end
    test_id <= 2;
    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      run_access(1'b1, 8 + i / 4, i % 4, rnd);
    end
    for (int i = 0; i < 16; i++) begin
      run_access(1'b0, 8 + i / 4, i % 4, '0);
    end
    // Five dirty lines in set 1 force write-backs
    test_id <= 3;
    for (int k = 0; k < 5; k++) begin
      rnd = $random(seed);
      run_access(1'b1, 81 + 4 * k, k % 4, rnd);
    end
    for (int k = 0; k < 5; k++) begin
      run_access(1'b0, 81 + 4 * k, k % 4, '0);
    end
    // Set 2: A B C D, A again, then E evicts B
    test_id <= 4;
    run_access(1'b0, 162, 0, '0);
    run_access(1'b0, 166, 0, '0);
    run_access(1'b0, 170, 0, '0);
    run_access(1'b0, 174, 0, '0);
    run_access(1'b0, 162, 1, '0);
    run_access(1'b0, 178, 0, '0);
    run_access(1'b0, 166, 1, '0);
    run_access(1'b0, 162, 2, '0);
    test_id <= 5;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      rnd = $random(seed);
      data = $random(seed);
      run_access(rnd[0], 32'(rnd[15:8]) % RANDOM_LINES, 32'(rnd[3:2]), data);
    end
    test_id <= 0;
    req <= '0;
    repeat (2) @(posedge clk);
    if (error_count == 0 && check_count > 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+include
rtl/cache_pkg.sv
rtl/cache_lookup.sv
rtl/data_cache.sv
rtl/data_memory.sv
rtl/cache_top.sv
verif/cache_checker.sv
verif/cache_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build cache_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module cache_tb -f files.f -Mdir obj_dir
	./obj_dir/Vcache_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "test: FAIL"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "test: no verdict in $(LOG)"; exit 1; fi
	@echo "test: PASS"

clean:
	rm -rf obj_dir $(LOG)
